/* config_regmap.sv */
`default_nettype none

module config_regmap (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                cfg_req_i,    // four-phase request
    input  larpix_pkg::cfg_write_t              cfg_wr_i,     // held stable during req
    output logic                                cfg_ack_o,
    output larpix_pkg::trig_cfg_t               trig_cfg_o,   // decoded trigger config
    output logic [larpix_pkg::CHIP_ID_W-1:0]    chip_id_o
);

    localparam int W          = larpix_pkg::WORDWIDTH;
    localparam int MASK_BYTES = larpix_pkg::NUMCHANNELS / W;   // bytes per mask
    localparam int CYC_BYTES  = 32 / W;                        // bytes of period

    logic [W-1:0] regs_q [larpix_pkg::REGNUM];    // byte-wide register file

    ////////////////////////////////////////////////////////////
    // write handshake
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_ack_o <= 1'b0;
            for (int r = 0; r < larpix_pkg::REGNUM; r++) begin
                regs_q[r] <= '0;
            end
        end else if (cfg_req_i && !cfg_ack_o) begin    // one write per new request
            regs_q[cfg_wr_i.addr] <= cfg_wr_i.data;
            cfg_ack_o             <= 1'b1;
        end else if (!cfg_req_i) begin
            cfg_ack_o <= 1'b0;                           // release once req drops
        end
    end

    ////////////////////////////////////////////////////////////
    // field decode
    ////////////////////////////////////////////////////////////
    assign chip_id_o = regs_q[larpix_pkg::REG_CHIP_ID];

    always_comb begin
        trig_cfg_o.cross_en    = regs_q[larpix_pkg::REG_TRIG_MODES][0];
        trig_cfg_o.periodic_en = regs_q[larpix_pkg::REG_TRIG_MODES][1];
        for (int b = 0; b < CYC_BYTES; b++) begin     // period bytes in lsb-first order
            trig_cfg_o.per_trig_cyc[b*W +: W] = regs_q[larpix_pkg::REG_PER_TRIG_CYC + b];
        end
        for (int b = 0; b < MASK_BYTES; b++) begin    // mask bytes in lsb-first order
            trig_cfg_o.channel_mask[b*W +: W]    = regs_q[larpix_pkg::REG_CHANNEL_MASK + b];
            trig_cfg_o.ext_trig_mask[b*W +: W]   = regs_q[larpix_pkg::REG_EXT_TRIG_MASK + b];
            trig_cfg_o.cross_trig_mask[b*W +: W] = regs_q[larpix_pkg::REG_CROSS_TRIG_MASK + b];
            trig_cfg_o.per_trig_mask[b*W +: W]   = regs_q[larpix_pkg::REG_PER_TRIG_MASK + b];
        end
    end

    // ack only ever answers a live request
    ack_follows_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(cfg_ack_o) |-> $past(cfg_req_i));

    // master keeps the written word steady until it drops req
    wr_held_during_ack: assert property (@(posedge clk) disable iff (reset_i)
        (cfg_req_i && cfg_ack_o) |-> $stable(cfg_wr_i));

endmodule

`default_nettype wire

/* digital_core.sv */
`default_nettype none

module digital_core #(
    parameter int NUMCHANNELS = larpix_pkg::NUMCHANNELS,  // analog channels
    parameter int FIFO_DEPTH  = larpix_pkg::FIFO_DEPTH,   // shared event fifo
    parameter int PER_TRIG_W  = 32                        // periodic counter width
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [NUMCHANNELS-1:0]      hit_i,               // discriminator fired
    input  logic                        external_trigger_i,
    input  logic                        cfg_req_i,           // config write port
    input  larpix_pkg::cfg_write_t      cfg_wr_i,
    output logic                        cfg_ack_o,
    output larpix_pkg::chan_event_t     evt_o,               // event readout port
    output logic                        evt_req_o,
    input  logic                        evt_ack_i
);

    larpix_pkg::trig_cfg_t                      trig_cfg;
    logic [larpix_pkg::CHIP_ID_W-1:0]           chip_id;
    logic                                       per_pulse;
    logic [NUMCHANNELS-1:0]                     trig_valid;
    larpix_pkg::trig_type_e [NUMCHANNELS-1:0]   trig_type;
    logic                                       fifo_full;
    logic                                       fifo_wr;
    larpix_pkg::chan_event_t                    rtr_event;   // router to fifo

    config_regmap config_regmap_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .cfg_req_i  (cfg_req_i),
        .cfg_wr_i   (cfg_wr_i),
        .cfg_ack_o  (cfg_ack_o),
        .trig_cfg_o (trig_cfg),
        .chip_id_o  (chip_id)
    );

    periodic_pulser #(.PULSER_W(PER_TRIG_W)) periodic_trigger_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (trig_cfg.periodic_en),
        .pulse_cycles_i (trig_cfg.per_trig_cyc[PER_TRIG_W-1:0]),
        .pulse_o        (per_pulse)
    );

    trigger_logic #(.NUMCHANNELS(NUMCHANNELS)) trigger_logic_inst (
        .clk                (clk),
        .reset_i            (reset_i),
        .hit_i              (hit_i),
        .external_trigger_i (external_trigger_i),
        .per_pulse_i        (per_pulse),
        .trig_cfg_i         (trig_cfg),
        .trig_valid_o       (trig_valid),
        .trig_type_o        (trig_type)
    );

    event_router #(.NUMCHANNELS(NUMCHANNELS)) event_router_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .trig_valid_i (trig_valid),
        .trig_type_i  (trig_type),
        .chip_id_i    (chip_id),
        .fifo_full_i  (fifo_full),
        .fifo_wr_o    (fifo_wr),
        .event_o      (rtr_event)
    );

    event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) event_fifo_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .wr_i      (fifo_wr),
        .event_i   (rtr_event),
        .full_o    (fifo_full),
        .evt_o     (evt_o),
        .evt_req_o (evt_req_o),
        .evt_ack_i (evt_ack_i)
    );

endmodule

`default_nettype wire

/* event_fifo.sv */
`default_nettype none

module event_fifo #(
    parameter int FIFO_DEPTH = larpix_pkg::FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        wr_i,        // push from router
    input  larpix_pkg::chan_event_t     event_i,
    output logic                        full_o,
    output larpix_pkg::chan_event_t     evt_o,       // head under handshake
    output logic                        evt_req_o,
    input  logic                        evt_ack_i
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    larpix_pkg::chan_event_t mem [FIFO_DEPTH];       // event storage
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [CNT_W-1:0]        count_q;                // entries held
    logic                    pop;

    assign full_o = (count_q == CNT_W'(FIFO_DEPTH));
    assign pop    = evt_req_o & evt_ack_i;           // consumer took the head

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_ptr_q] <= event_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers, count and readout handshake
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            evt_req_o <= 1'b0;
            evt_o     <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(wr_i) - CNT_W'(pop);
            if (pop) begin
                evt_req_o <= 1'b0;                             // drop req on ack
            end else if (!evt_req_o && !evt_ack_i && count_q != '0) begin
                evt_o     <= mem[rd_ptr_q];                    // present next head
                evt_req_o <= 1'b1;
            end
        end
    end

    no_overflow: assert property (@(posedge clk) disable iff (reset_i)
        count_q <= CNT_W'(FIFO_DEPTH));

    // head and req hold until the consumer acks
    req_stable: assert property (@(posedge clk) disable iff (reset_i)
        (evt_req_o && !evt_ack_i) |=> (evt_req_o && $stable(evt_o)));

endmodule

`default_nettype wire

/* event_router.sv */
`default_nettype none

module event_router #(
    parameter int NUMCHANNELS = larpix_pkg::NUMCHANNELS
) (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  logic [NUMCHANNELS-1:0]                      trig_valid_i,
    input  larpix_pkg::trig_type_e [NUMCHANNELS-1:0]    trig_type_i,
    input  logic [larpix_pkg::CHIP_ID_W-1:0]            chip_id_i,
    input  logic                                        fifo_full_i,
    output logic                                        fifo_wr_o,   // event stored
    output larpix_pkg::chan_event_t                     event_o
);

    localparam int IDX_W = larpix_pkg::CHAN_ID_W;
    localparam int TS_W  = larpix_pkg::TIMESTAMP_W;

    logic [NUMCHANNELS-1:0] pending_q;                  // one slot per channel
    larpix_pkg::trig_type_e pend_type_q [NUMCHANNELS];
    logic [TS_W-1:0]        pend_ts_q   [NUMCHANNELS];
    logic [TS_W-1:0]        timestamp_q;                // free running
    logic [IDX_W-1:0]       last_q;                     // last granted channel
    logic [IDX_W-1:0]       grant_idx;
    logic                   grant_vld;

    ////////////////////////////////////////////////////////////
    // round-robin arbiter starting after the last grant
    ////////////////////////////////////////////////////////////
    always_comb begin : rr_arb
        int idx;
        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int i = 1; i <= NUMCHANNELS; i++) begin
            idx = (int'(last_q) + i) % NUMCHANNELS;
            if (!grant_vld && pending_q[idx]) begin
                grant_vld = 1'b1;
                grant_idx = idx[IDX_W-1:0];
            end
        end
    end

    assign fifo_wr_o = grant_vld & ~fifo_full_i;      // hold off on back-pressure

    always_comb begin
        event_o.chip_id    = chip_id_i;
        event_o.channel_id = grant_idx;
        event_o.trig_type  = pend_type_q[grant_idx];
        event_o.timestamp  = pend_ts_q[grant_idx];
    end

    ////////////////////////////////////////////////////////////
    // pending slots and timestamp
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending_q   <= '0;
            timestamp_q <= '0;
            last_q      <= '0;
            for (int i = 0; i < NUMCHANNELS; i++) begin
                pend_type_q[i] <= larpix_pkg::NATURAL;
                pend_ts_q[i]   <= '0;
            end
        end else begin
            timestamp_q <= timestamp_q + 1'b1;
            for (int i = 0; i < NUMCHANNELS; i++) begin
                if (trig_valid_i[i] && !pending_q[i]) begin   // busy slot drops it
                    pending_q[i]   <= 1'b1;
                    pend_type_q[i] <= trig_type_i[i];
                    pend_ts_q[i]   <= timestamp_q;
                end
            end
            if (fifo_wr_o) begin
                pending_q[grant_idx] <= 1'b0;                 // event handed off
                last_q               <= grant_idx;
            end
        end
    end

    // same channel granted again only when no other channel waits
    rr_no_repeat: assert property (@(posedge clk) disable iff (reset_i)
        (fifo_wr_o && grant_idx == last_q) |-> $onehot(pending_q));

endmodule

`default_nettype wire

/* larpix_pkg.sv */
`default_nettype none

package larpix_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////
    localparam int NUMCHANNELS = 16;    // default channel count
    localparam int CHAN_ID_W   = 4;     // channel id bits
    localparam int CHIP_ID_W   = 8;     // chip id bits
    localparam int TIMESTAMP_W = 16;    // event timestamp bits
    localparam int WORDWIDTH   = 8;     // register width
    localparam int REGNUM      = 16;    // number of config registers
    localparam int FIFO_DEPTH  = 8;     // default event fifo depth

    ////////////////////////////////////////////////////////////
    // register map, multi-byte fields are lsb first
    ////////////////////////////////////////////////////////////
    localparam int REG_CHIP_ID         = 0;
    localparam int REG_TRIG_MODES      = 1;     // [0] cross en, [1] periodic en
    localparam int REG_PER_TRIG_CYC    = 2;     // 4 bytes, 2..5
    localparam int REG_CHANNEL_MASK    = 6;     // 6..7
    localparam int REG_EXT_TRIG_MASK   = 8;     // 8..9
    localparam int REG_CROSS_TRIG_MASK = 10;    // 10..11
    localparam int REG_PER_TRIG_MASK   = 12;    // 12..13

    typedef enum logic [1:0] {
        NATURAL  = 2'd0,    // highest priority
        EXTERNAL = 2'd1,
        CROSS    = 2'd2,
        PERIODIC = 2'd3     // lowest priority
    } trig_type_e;

    typedef struct packed {
        logic [3:0]           addr;     // register address
        logic [WORDWIDTH-1:0] data;     // byte to write
    } cfg_write_t;

    // masks: high bit disables the channel
    typedef struct packed {
        logic                   cross_en;
        logic                   periodic_en;
        logic [31:0]            per_trig_cyc;      // periodic period
        logic [NUMCHANNELS-1:0] channel_mask;
        logic [NUMCHANNELS-1:0] ext_trig_mask;
        logic [NUMCHANNELS-1:0] cross_trig_mask;
        logic [NUMCHANNELS-1:0] per_trig_mask;
    } trig_cfg_t;

    typedef struct packed {
        logic [CHIP_ID_W-1:0]   chip_id;
        logic [CHAN_ID_W-1:0]   channel_id;
        trig_type_e             trig_type;
        logic [TIMESTAMP_W-1:0] timestamp;   // cycle the trigger was seen
    } chan_event_t;

endpackage

`default_nettype wire

/* periodic_pulser.sv */
`default_nettype none

module periodic_pulser #(
    parameter int PULSER_W = 32                  // period counter width
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                enable_i,
    input  logic [PULSER_W-1:0] pulse_cycles_i,  // pulse every N+1 cycles
    output logic                pulse_o          // one-cycle strobe
);

    logic [PULSER_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
            pulse_o <= 1'b0;
        end else if (!enable_i) begin
            count_q <= '0;                       // park at zero while off
            pulse_o <= 1'b0;
        end else if (count_q >= pulse_cycles_i) begin
            count_q <= '0;                       // wrap, also if period shrank
            pulse_o <= (pulse_cycles_i != '0);   // zero period gives no pulse
        end else begin
            count_q <= count_q + 1'b1;
            pulse_o <= 1'b0;
        end
    end

    // back-to-back pulses would double-trigger every channel
    single_cycle_pulse: assert property (@(posedge clk) disable iff (reset_i)
        pulse_o |=> !pulse_o);

endmodule

`default_nettype wire

/* tb_digital_core.sv */
`default_nettype none

module tb_digital_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NCH         = larpix_pkg::NUMCHANNELS;
    localparam int NUM_ROWS    = 7;
    localparam int NUM_WRITES  = 13;
    localparam int CYCLE_LIMIT = 200 * NUM_ROWS + 1000;   // per-row budget plus slack
    localparam int PER_REG     = larpix_pkg::REG_PER_TRIG_CYC;
    localparam logic [3:0] MODES_ADDR = larpix_pkg::REG_TRIG_MODES;

    localparam logic [1:0] STIM_HITS = 2'd0;   // one-cycle hit vector
    localparam logic [1:0] STIM_EXT  = 2'd1;   // one-cycle external pulse
    localparam logic [1:0] STIM_PER  = 2'd2;   // periodic run, stim is length

    typedef struct packed {
        logic [1:0]  kind;
        logic [15:0] stim;        // hit vector or run length
        logic [15:0] exp_mask;    // channels that must report
        logic [31:0] exp_types;   // 2 bits per channel
        logic [1:0]  reps;        // events per reporting channel
        logic [7:0]  ack_hold;    // delay before first ack
        logic [3:0]  ack_rand;    // mask on random ack delay
    } row_t;

    typedef struct packed {
        logic [3:0]             row;   // row that applies it
        larpix_pkg::cfg_write_t wr;
    } wr_entry_t;

    logic                    clk;
    logic                    reset_i;
    logic [NCH-1:0]          hit_i;
    logic                    external_trigger_i;
    logic                    cfg_req_i;
    larpix_pkg::cfg_write_t  cfg_wr_i;
    logic                    cfg_ack_o;
    larpix_pkg::chan_event_t evt_o;
    logic                    evt_req_o;
    logic                    evt_ack_i;

    row_t        rows   [NUM_ROWS];
    wr_entry_t   writes [NUM_WRITES];
    logic [7:0]  shadow [larpix_pkg::REGNUM];   // model of the register file
    logic [31:0] lcg_state;
    logic [15:0] last_ts;                       // latest timestamp of the run
    int          cycles = 0;

    digital_core #(.NUMCHANNELS(NCH), .FIFO_DEPTH(larpix_pkg::FIFO_DEPTH),
                   .PER_TRIG_W(32)) dut_i (
        .clk                (clk),
        .reset_i            (reset_i),
        .hit_i              (hit_i),
        .external_trigger_i (external_trigger_i),
        .cfg_req_i          (cfg_req_i),
        .cfg_wr_i           (cfg_wr_i),
        .cfg_ack_o          (cfg_ack_o),
        .evt_o              (evt_o),
        .evt_req_o          (evt_req_o),
        .evt_ack_i          (evt_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic wr_entry_t make_write(input int row, input int addr,
                                             input logic [7:0] data);
        wr_entry_t e;
        e.row     = row[3:0];
        e.wr.addr = addr[3:0];
        e.wr.data = data;
        return e;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////
    // config write, four-phase
    ////////////////////////////////////////////////////////////
    task automatic write_reg(input larpix_pkg::cfg_write_t w);
        int n;
        @(posedge clk);
        cfg_wr_i  <= w;
        cfg_req_i <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cfg_ack_o && n < 8);
        assert (n == 2) else report_error($sformatf("cfg ack rose at sample %0d, not 2", n));
        @(posedge clk);
        cfg_req_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (cfg_ack_o && n < 8);
        assert (n == 2) else report_error($sformatf("cfg ack fell at sample %0d, not 2", n));
        shadow[w.addr] = w.data;                 // in effect from here on
    endtask

    task automatic apply_stimulus(input row_t r);
        case (r.kind)
            STIM_HITS: begin
                @(posedge clk);
                hit_i <= r.stim[NCH-1:0];
                @(posedge clk);
                hit_i <= '0;
            end
            STIM_EXT: begin
                @(posedge clk);
                external_trigger_i <= 1'b1;
                @(posedge clk);
                external_trigger_i <= 1'b0;
            end
            default: begin                       // pulser on for a while, then off
                write_reg({MODES_ADDR, 8'h02});
                repeat (r.stim) @(posedge clk);
                write_reg({MODES_ADDR, 8'h00});
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // readout consumer, compares as a set
    ////////////////////////////////////////////////////////////
    task automatic collect_events(input row_t r);
        int                      total;
        int                      got;
        int                      delay;
        int                      ch;
        int                      seen    [NCH];
        logic [15:0]             prev_ts [NCH];
        logic [31:0]             period;
        larpix_pkg::chan_event_t ev;
        total  = $countones(r.exp_mask) * r.reps;
        period = {shadow[PER_REG+3], shadow[PER_REG+2], shadow[PER_REG+1], shadow[PER_REG]};
        for (int i = 0; i < NCH; i++) begin
            seen[i]    = 0;
            prev_ts[i] = '0;
        end
        got = 0;
        while (got < total) begin
            @(negedge clk);
            while (!evt_req_o) @(negedge clk);
            ev = evt_o;
            ch = ev.channel_id;
            assert (ev.chip_id == shadow[larpix_pkg::REG_CHIP_ID])
                else report_error($sformatf("chip id %0h on channel %0d", ev.chip_id, ch));
            assert (r.exp_mask[ch] && seen[ch] < r.reps)
                else report_error($sformatf("unexpected event on channel %0d", ch));
            assert (ev.trig_type == r.exp_types[2*ch +: 2])
                else report_error($sformatf("channel %0d type %0d", ch, ev.trig_type));
            assert (ev.timestamp >= last_ts)
                else report_error($sformatf("timestamp %0d went backwards", ev.timestamp));
            if (seen[ch] > 0)                    // periodic spacing is N+1
                assert (ev.timestamp - prev_ts[ch] == period[15:0] + 16'd1)
                    else report_error($sformatf("channel %0d periodic spacing", ch));
            prev_ts[ch] = ev.timestamp;
            seen[ch]++;
            last_ts = ev.timestamp;
            got++;
            lcg_state = lcg_next(lcg_state);
            delay = (got == 1) ? int'(r.ack_hold) : int'(lcg_state[19:16] & r.ack_rand);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            evt_ack_i <= 1'b1;
            do @(negedge clk); while (evt_req_o);   // fifo drops req on ack
            @(posedge clk);
            evt_ack_i <= 1'b0;
        end
        repeat (20) begin
            @(negedge clk);
            assert (!evt_req_o) else report_error("extra event after the expected set");
        end
    endtask

    initial begin
        reset_i            = 1'b1;
        hit_i              = '0;
        external_trigger_i = 1'b0;
        cfg_req_i          = 1'b0;
        cfg_wr_i           = '0;
        evt_ack_i          = 1'b0;
        lcg_state          = 32'h5d9cdde1;
        last_ts            = '0;
        for (int i = 0; i < larpix_pkg::REGNUM; i++) begin
            shadow[i] = '0;
        end
        writes[0]  = make_write(0, larpix_pkg::REG_CHIP_ID, 8'hA5);
        writes[1]  = make_write(1, larpix_pkg::REG_CHANNEL_MASK, 8'h0C);      // ch 2,3
        writes[2]  = make_write(1, larpix_pkg::REG_CHANNEL_MASK + 1, 8'h80);  // ch 15
        writes[3]  = make_write(2, larpix_pkg::REG_EXT_TRIG_MASK, 8'hF0);
        writes[4]  = make_write(2, larpix_pkg::REG_EXT_TRIG_MASK + 1, 8'h0F);
        writes[5]  = make_write(3, larpix_pkg::REG_TRIG_MODES, 8'h01);        // cross on
        writes[6]  = make_write(3, larpix_pkg::REG_CROSS_TRIG_MASK + 1, 8'h40);
        writes[7]  = make_write(4, larpix_pkg::REG_TRIG_MODES, 8'h00);
        writes[8]  = make_write(5, larpix_pkg::REG_PER_TRIG_CYC, 8'd29);      // period 30
        writes[9]  = make_write(5, larpix_pkg::REG_PER_TRIG_MASK, 8'hFE);
        writes[10] = make_write(5, larpix_pkg::REG_PER_TRIG_MASK + 1, 8'hDF);
        writes[11] = make_write(6, larpix_pkg::REG_CHANNEL_MASK, 8'h00);
        writes[12] = make_write(6, larpix_pkg::REG_CHANNEL_MASK + 1, 8'h00);
        // kind, stim, exp_mask, exp_types, reps, ack_hold, ack_rand
        rows[0] = {STIM_HITS, 16'h0013, 16'h0013, 32'h0000_0000, 2'd1, 8'd0, 4'h3};
        rows[1] = {STIM_HITS, 16'h800F, 16'h0003, 32'h0000_0000, 2'd1, 8'd0, 4'h3};
        rows[2] = {STIM_EXT,  16'h0000, 16'h7003, 32'h5555_5555, 2'd1, 8'd0, 4'h3};
        rows[3] = {STIM_HITS, 16'h0001, 16'h3FF3, 32'hAAAA_AAA8, 2'd1, 8'd0, 4'h7};
        rows[4] = {STIM_HITS, 16'h0020, 16'h0020, 32'h0000_0000, 2'd1, 8'd0, 4'h3};
        rows[5] = {STIM_PER,  16'd70,   16'h2001, 32'hFFFF_FFFF, 2'd2, 8'd0, 4'h3};
        rows[6] = {STIM_HITS, 16'hFFFF, 16'hFFFF, 32'h0000_0000, 2'd1, 8'd40, 4'h1};
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int w = 0; w < NUM_WRITES; w++) begin
                if (writes[w].row == r) write_reg(writes[w].wr);
            end
            apply_stimulus(rows[r]);
            collect_events(rows[r]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* trigger_logic.sv */
`default_nettype none

module trigger_logic #(
    parameter int NUMCHANNELS = larpix_pkg::NUMCHANNELS
) (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  logic [NUMCHANNELS-1:0]                      hit_i,              // discriminators
    input  logic                                        external_trigger_i, // async
    input  logic                                        per_pulse_i,
    input  larpix_pkg::trig_cfg_t                       trig_cfg_i,
    output logic [NUMCHANNELS-1:0]                      trig_valid_o,
    output larpix_pkg::trig_type_e [NUMCHANNELS-1:0]    trig_type_o
);

    logic                   ext_meta_q;     // first sync stage
    logic                   ext_sync_q;     // second sync stage
    logic                   cross_any;      // any natural hit, cross enabled
    logic [NUMCHANNELS-1:0] nat_hit;
    logic [NUMCHANNELS-1:0] ext_trig;
    logic [NUMCHANNELS-1:0] cross_trig;
    logic [NUMCHANNELS-1:0] per_trig;

    ////////////////////////////////////////////////////////////
    // source qualification
    ////////////////////////////////////////////////////////////
    always_comb begin
        nat_hit    = hit_i & ~trig_cfg_i.channel_mask;
        cross_any  = trig_cfg_i.cross_en & (|nat_hit);
        ext_trig   = {NUMCHANNELS{ext_sync_q}} & ~trig_cfg_i.ext_trig_mask
                     & ~trig_cfg_i.channel_mask;
        cross_trig = {NUMCHANNELS{cross_any}} & ~trig_cfg_i.cross_trig_mask
                     & ~trig_cfg_i.channel_mask;
        per_trig   = {NUMCHANNELS{per_pulse_i}} & ~trig_cfg_i.per_trig_mask
                     & ~trig_cfg_i.channel_mask;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ext_meta_q   <= 1'b0;
            ext_sync_q   <= 1'b0;
            trig_valid_o <= '0;
            for (int i = 0; i < NUMCHANNELS; i++) begin
                trig_type_o[i] <= larpix_pkg::NATURAL;
            end
        end else begin
            ext_meta_q   <= external_trigger_i;
            ext_sync_q   <= ext_meta_q;
            trig_valid_o <= nat_hit | ext_trig | cross_trig | per_trig;
            for (int i = 0; i < NUMCHANNELS; i++) begin    // priority encode
                if (nat_hit[i])         trig_type_o[i] <= larpix_pkg::NATURAL;
                else if (ext_trig[i])   trig_type_o[i] <= larpix_pkg::EXTERNAL;
                else if (cross_trig[i]) trig_type_o[i] <= larpix_pkg::CROSS;
                else                    trig_type_o[i] <= larpix_pkg::PERIODIC;
            end
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
larpix_pkg.sv
config_regmap.sv
periodic_pulser.sv
trigger_logic.sv
event_router.sv
event_fifo.sv
digital_core.sv
tb_digital_core.sv
